// ==== vlog.f ====
common/fetch_pkg.sv
common/line_req_if.sv
prefetcher/line_tracker.sv
prefetcher/prefetch_fsm.sv
icache/icache_store.sv
icache/icache_fill.sv
design/burst_counter.sv
design/fetch_top.sv
testbench/fetch_mem_model.sv
testbench/fetch_tb.sv

// ==== testbench/fetch_tb.sv ====
`timescale 1ns/1ns

module fetch_tb;
    import fetch_pkg::*;

    localparam int unsigned rand_seed      = 32'hd7dc_d723;
    localparam int unsigned timeout_cycles = 200;

    logic  clk;
    logic  rst;
    addr_t cpu_address;
    logic  cpu_read;
    line_t cpu_rdata;
    logic  cpu_resp;
    logic  branch_taken;
    logic  arbiter_idle;
    addr_t mem_address;
    logic  mem_read;
    beat_t mem_rdata;
    logic  mem_beat_valid;

    // observed bursts and a shadow of the direct-mapped tags
    addr_t       burst_log[$];
    int unsigned resp_count;
    logic        mem_read_q;
    addr_t       shadow_line  [2 ** index_bits];
    logic        shadow_valid [2 ** index_bits];

    fetch_top dut_i (.*);

    fetch_mem_model #(.seed(rand_seed)) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic addr_t line_of(input addr_t address);
        return {address[31:offset_bits], {offset_bits{1'b0}}};
    endfunction

    function automatic line_t expected_line(input addr_t address);
        line_t line;
        for (int k = 0; k < beats_per_line; k++) begin
            line[k*beat_bits +: beat_bits] = {line_of(address), 32'(k)};
        end
        return line;
    endfunction

    function automatic logic cached(input addr_t address);
        int unsigned idx;
        idx = address[offset_bits +: index_bits];
        return shadow_valid[idx] && (shadow_line[idx] == line_of(address));
    endfunction

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic value_error(input string msg);
        $display("** Error at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic timed_out(input string what);
        $display("timed out waiting for %s", what);
        stop_run();
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // sampled mid-cycle, every burst start fills the shadow
    always @(negedge clk) begin
        if (!rst) begin
            if (mem_read && !mem_read_q) begin
                burst_log.push_back(mem_address);
                shadow_line[mem_address[offset_bits +: index_bits]]  = mem_address;
                shadow_valid[mem_address[offset_bits +: index_bits]] = 1'b1;
            end
            assert (!mem_read || mem_address == line_of(mem_address))
                else value_error($sformatf("mem_address %h not line aligned", mem_address));
            assert (!(mem_read && mem_read_q) || mem_address == burst_log[$])
                else value_error("mem_address changed during a burst");
            if (cpu_resp) resp_count++;
            mem_read_q = mem_read;
        end
    end

    task automatic fetch_line(input addr_t address, output int unsigned cycles);
        int unsigned waited;
        step();
        cpu_address = address;
        cpu_read    = 1'b1;  // held until cpu_resp
        waited      = 0;
        @(negedge clk);
        while (!cpu_resp) begin
            if (waited == timeout_cycles) timed_out("cpu_resp");
            waited++;
            @(negedge clk);
        end
        cycles = waited;
        assert (cpu_rdata == expected_line(address))
            else value_error($sformatf("wrong cpu_rdata for %h", address));
        step();
        cpu_read = 1'b0;
    endtask

    // hit or miss as the shadow predicts
    task automatic check_fetch(input addr_t address);
        int unsigned cycles;
        int unsigned bursts;
        logic        hit;
        hit    = cached(address);
        bursts = burst_log.size();
        fetch_line(address, cycles);
        if (hit) begin
            assert (cycles == 1 && burst_log.size() == bursts)
                else value_error($sformatf("hit on %h took %0d cycles", address, cycles));
        end else begin
            assert (burst_log.size() == bursts + 1 && burst_log[$] == line_of(address))
                else value_error($sformatf("miss on %h did not burst once", address));
        end
    endtask

    task automatic wait_burst(input addr_t address);
        int unsigned bursts;
        int unsigned waited;
        bursts = burst_log.size();
        waited = 0;
        while (burst_log.size() == bursts) begin
            if (waited == timeout_cycles) timed_out("a memory burst");
            waited++;
            step();
        end
        assert (burst_log[$] == address)
            else value_error($sformatf("burst to %h, expected %h", burst_log[$], address));
    endtask

    // whole prefetch burst, never seen by the cpu
    task automatic prefetch_fill(input addr_t address);
        int unsigned resps;
        int unsigned waited;
        resps  = resp_count;
        waited = 0;
        wait_burst(address);
        while (mem_read_q) begin
            if (waited == timeout_cycles) timed_out("the end of a prefetch burst");
            waited++;
            step();
        end
        assert (resp_count == resps) else value_error("cpu_resp during a prefetch");
    endtask

    task automatic quiet_window();
        int unsigned bursts;
        int unsigned resps;
        bursts = burst_log.size();
        resps  = resp_count;
        repeat (12) step();
        assert (burst_log.size() == bursts && resp_count == resps)
            else value_error("unexpected burst or cpu_resp while idle");
    endtask

    initial begin
        int unsigned cycles;
        int unsigned bursts;
        int unsigned resps;
        rst          = 1'b1;
        cpu_address  = '0;
        cpu_read     = 1'b0;
        branch_taken = 1'b0;
        arbiter_idle = 1'b0;
        resp_count   = 0;
        mem_read_q   = 1'b0;
        for (int i = 0; i < 2 ** index_bits; i++) begin
            shadow_valid[i] = 1'b0;
        end
        repeat (8) step();
        rst = 1'b0;
        @(negedge clk);
        assert (!cpu_resp && !mem_read) else value_error("outputs active after reset");

        check_fetch(32'h0000_1004);  // cold miss
        quiet_window();              // arbiter busy, no prefetch
        check_fetch(32'h0000_100c);  // hit

        step();
        arbiter_idle = 1'b1;
        prefetch_fill(32'h0000_1020);
        quiet_window();              // no second prefetch of the same line
        check_fetch(32'h0000_1030);  // prefetched line hits
        quiet_window();
        check_fetch(32'h0000_1044);
        prefetch_fill(32'h0000_1060);

        // branch after a demand holds the prefetcher off
        step();
        arbiter_idle = 1'b0;
        check_fetch(32'h0000_1088);
        step();
        branch_taken = 1'b1;
        step();
        branch_taken = 1'b0;
        arbiter_idle = 1'b1;
        quiet_window();
        check_fetch(32'h0000_10a4);

        // demand raised in the middle of a prefetch burst
        resps  = resp_count;
        bursts = burst_log.size();
        wait_burst(32'h0000_10c0);
        fetch_line(32'h0000_10e8, cycles);
        assert (burst_log.size() == bursts + 2 && burst_log[$] == 32'h0000_10e0)
            else value_error("demand burst after the prefetch missing");
        prefetch_fill(32'h0000_1100);  // replaces line 0x1000
        assert (resp_count == resps + 1) else value_error("cpu_resp count wrong");

        step();
        arbiter_idle = 1'b0;
        check_fetch(32'h0000_10c8);
        check_fetch(32'h0000_1010);  // evicted, misses again
        quiet_window();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== testbench/fetch_mem_model.sv ====
`timescale 1ns/1ns

module fetch_mem_model #(
    parameter int unsigned seed = 32'h1
) (
    input  logic             clk,
    input  fetch_pkg::addr_t mem_address,
    input  logic             mem_read,
    output fetch_pkg::beat_t mem_rdata,
    output logic             mem_beat_valid
);
    import fetch_pkg::*;

    // one line burst at a time; beat k carries {line address, k}
    addr_t       line_address;
    int unsigned beats_sent;
    int unsigned gap;
    logic        busy;

    initial begin
        void'($urandom(seed));
        mem_rdata      = '0;
        mem_beat_valid = 1'b0;
        line_address   = '0;
        busy           = 1'b0;
        beats_sent     = 0;
        gap            = 0;
        forever begin
            @(negedge clk);
            if (mem_beat_valid) begin
                beats_sent++;
                busy = (beats_sent < beats_per_line);  // done after the last beat
            end else if (!busy && mem_read) begin
                busy         = 1'b1;
                beats_sent   = 0;
                line_address = mem_address;
                gap          = $urandom_range(3, 0);
            end
            @(posedge clk);
            #1;
            mem_beat_valid = 1'b0;
            if (busy && gap == 0) begin
                mem_beat_valid = 1'b1;
                mem_rdata      = {line_address, 32'(beats_sent)};
                gap            = $urandom_range(3, 0);  // idle cycles before the next beat
            end else if (busy) begin
                gap--;
            end
        end
    end

endmodule

// ==== design/fetch_top.sv ====
`timescale 1ns/1ns

module fetch_top (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t cpu_address,
    input  logic             cpu_read,
    output fetch_pkg::line_t cpu_rdata,
    output logic             cpu_resp,
    input  logic             branch_taken,
    input  logic             arbiter_idle,
    output fetch_pkg::addr_t mem_address,
    output logic             mem_read,
    input  fetch_pkg::beat_t mem_rdata,
    input  logic             mem_beat_valid
);
    import fetch_pkg::*;

    // prefetcher to tracker
    logic  demand_start;
    logic  demand_done;
    logic  prefetch_done;
    addr_t done_address;
    addr_t prefetch_address;
    logic  prefetch_allowed;

    // cache control to store and counter
    index_t    index;
    logic      write;
    tag_t      write_tag;
    line_t     write_line;
    tag_t      read_tag;
    logic      hit;
    line_t     read_line;
    beat_idx_t beat_index;
    logic      last_beat;
    logic      count_clear;

    line_req_if req_if ();

    prefetch_fsm prefetch_fsm_i (
        .clk              (clk),
        .rst              (rst),
        .cpu_address      (cpu_address),
        .cpu_read         (cpu_read),
        .cpu_rdata        (cpu_rdata),
        .cpu_resp         (cpu_resp),
        .arbiter_idle     (arbiter_idle),
        .prefetch_address (prefetch_address),
        .prefetch_allowed (prefetch_allowed),
        .demand_start     (demand_start),
        .demand_done      (demand_done),
        .prefetch_done    (prefetch_done),
        .done_address     (done_address),
        .req              (req_if.requester)
    );

    line_tracker line_tracker_i (
        .clk              (clk),
        .rst              (rst),
        .branch_taken     (branch_taken),
        .demand_start     (demand_start),
        .demand_done      (demand_done),
        .prefetch_done    (prefetch_done),
        .done_address     (done_address),
        .prefetch_address (prefetch_address),
        .prefetch_allowed (prefetch_allowed)
    );

    icache_fill icache_fill_i (
        .clk            (clk),
        .rst            (rst),
        .req            (req_if.responder),
        .mem_address    (mem_address),
        .mem_read       (mem_read),
        .mem_rdata      (mem_rdata),
        .mem_beat_valid (mem_beat_valid),
        .beat_index     (beat_index),
        .last_beat      (last_beat),
        .count_clear    (count_clear),
        .index          (index),
        .write          (write),
        .write_tag      (write_tag),
        .write_line     (write_line),
        .read_tag       (read_tag),
        .hit            (hit),
        .read_line      (read_line)
    );

    icache_store icache_store_i (
        .clk        (clk),
        .rst        (rst),
        .index      (index),
        .write      (write),
        .write_tag  (write_tag),
        .write_line (write_line),
        .read_tag   (read_tag),
        .hit        (hit),
        .read_line  (read_line)
    );

    burst_counter burst_counter_i (
        .clk        (clk),
        .rst        (rst),
        .clear      (count_clear),
        .beat_valid (mem_beat_valid),
        .beat_index (beat_index),
        .last_beat  (last_beat)
    );

endmodule

// ==== design/burst_counter.sv ====
`timescale 1ns/1ns

module burst_counter (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  logic                 beat_valid,
    output fetch_pkg::beat_idx_t beat_index,
    output logic                 last_beat
);
    import fetch_pkg::*;

    beat_idx_t count;

    // wraps after the last beat of a line
    always_ff @(posedge clk) begin
        if (rst || clear) begin
            count <= '0;
        end else if (beat_valid) begin
            count <= count + 1'b1;
        end
    end

    assign beat_index = count;
    assign last_beat  = (count == beat_idx_t'(beats_per_line - 1));  // level, not a pulse

endmodule

// ==== icache/icache_fill.sv ====
`timescale 1ns/1ns

module icache_fill (
    input  logic                 clk,
    input  logic                 rst,
    line_req_if.responder        req,
    output fetch_pkg::addr_t     mem_address,
    output logic                 mem_read,
    input  fetch_pkg::beat_t     mem_rdata,
    input  logic                 mem_beat_valid,
    input  fetch_pkg::beat_idx_t beat_index,
    input  logic                 last_beat,
    output logic                 count_clear,
    output fetch_pkg::index_t    index,
    output logic                 write,
    output fetch_pkg::tag_t      write_tag,
    output fetch_pkg::line_t     write_line,
    output fetch_pkg::tag_t      read_tag,
    input  logic                 hit,
    input  fetch_pkg::line_t     read_line
);
    import fetch_pkg::*;

    typedef enum logic [1:0] {
        f_idle,
        f_lookup,  // registered address against the store
        f_burst,   // waiting on memory beats
        f_done     // write store and answer
    } fill_state_e;

    fill_state_e state;
    addr_t       addr_q;
    line_t       line_buf;
    logic        miss;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= f_idle;
        end else begin
            case (state)
                f_idle:   if (req.read) state <= f_lookup;
                f_lookup: state <= hit ? f_idle : f_burst;
                f_burst:  if (mem_beat_valid && last_beat) state <= f_done;
                default:  state <= f_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == f_idle && req.read) begin
            addr_q <= req.address;
        end
        // beats land by their position in the line
        if (mem_read && mem_beat_valid) begin
            line_buf[beat_index*beat_bits +: beat_bits] <= mem_rdata;
        end
    end

    assign miss = (state == f_lookup) && !hit;

    // memory burst, line aligned
    assign mem_read    = miss || (state == f_burst);
    assign mem_address = {addr_q[31:offset_bits], {offset_bits{1'b0}}};
    assign count_clear = (state == f_idle);

    assign index      = addr_q[offset_bits +: index_bits];
    assign read_tag   = addr_q[31 -: tag_bits];
    assign write_tag  = addr_q[31 -: tag_bits];
    assign write_line = line_buf;
    assign write      = (state == f_done);

    assign req.resp  = ((state == f_lookup) && hit) || (state == f_done);
    assign req.rdata = (state == f_done) ? line_buf : read_line;

endmodule

// ==== icache/icache_store.sv ====
`timescale 1ns/1ns

module icache_store (
    input  logic              clk,
    input  logic              rst,
    input  fetch_pkg::index_t index,
    input  logic              write,
    input  fetch_pkg::tag_t   write_tag,
    input  fetch_pkg::line_t  write_line,
    input  fetch_pkg::tag_t   read_tag,
    output logic              hit,
    output fetch_pkg::line_t  read_line
);
    import fetch_pkg::*;

    localparam int unsigned entries = 2 ** index_bits;

    logic  valid_q [entries];
    tag_t  tag_q   [entries];
    line_t data_q  [entries];

    // only the valid bits come out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < entries; i++) begin
                valid_q[i] <= 1'b0;
            end
        end else if (write) begin
            valid_q[index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            tag_q[index]  <= write_tag;
            data_q[index] <= write_line;
        end
    end

    // direct-mapped lookup
    assign hit       = valid_q[index] && (tag_q[index] == read_tag);
    assign read_line = data_q[index];

endmodule

// ==== prefetcher/prefetch_fsm.sv ====
`timescale 1ns/1ns

module prefetch_fsm (
    input  logic             clk,
    input  logic             rst,
    input  fetch_pkg::addr_t cpu_address,
    input  logic             cpu_read,
    output fetch_pkg::line_t cpu_rdata,
    output logic             cpu_resp,
    input  logic             arbiter_idle,
    input  fetch_pkg::addr_t prefetch_address,
    input  logic             prefetch_allowed,
    output logic             demand_start,
    output logic             demand_done,
    output logic             prefetch_done,
    output fetch_pkg::addr_t done_address,
    line_req_if.requester    req
);
    import fetch_pkg::*;

    pf_state_e state;
    pf_state_e next_state;

    always_comb begin
        next_state = state;
        case (state)
            idle: begin
                // demand always wins over a prefetch
                if (cpu_read) begin
                    next_state = serve;
                end else if (prefetch_allowed && arbiter_idle) begin
                    next_state = prefetch;
                end
            end
            serve: begin
                if (req.resp) begin
                    next_state = idle;
                end
            end
            prefetch: begin
                // a waiting cpu read is taken once back in idle
                if (req.resp) begin
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    // request goes out in the same cycle as the decision
    always_comb begin
        req.address = cpu_address;
        req.read    = 1'b0;
        cpu_resp    = 1'b0;
        case (state)
            idle: begin
                if (next_state == serve) begin
                    req.read = 1'b1;
                end else if (next_state == prefetch) begin
                    req.address = prefetch_address;
                    req.read    = 1'b1;
                end
            end
            serve: begin
                req.read = 1'b1;
                cpu_resp = req.resp;
            end
            prefetch: begin
                req.address = prefetch_address;
                req.read    = 1'b1;   // resp kept away from the cpu
            end
            default: ;
        endcase
    end

    assign cpu_rdata = req.rdata;

    // tracker events
    assign demand_start  = (state == idle) && cpu_read;
    assign demand_done   = (state == serve) && req.resp;
    assign prefetch_done = (state == prefetch) && req.resp;
    assign done_address  = cpu_address;  // stable through serve

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== prefetcher/line_tracker.sv ====
`timescale 1ns/1ns

module line_tracker (
    input  logic             clk,
    input  logic             rst,
    input  logic             branch_taken,
    input  logic             demand_start,
    input  logic             demand_done,
    input  logic             prefetch_done,
    input  fetch_pkg::addr_t done_address,
    output fetch_pkg::addr_t prefetch_address,
    output logic             prefetch_allowed
);
    import fetch_pkg::*;

    addr_t last_line;
    addr_t last_pf_line;
    logic  pf_valid;      // last_pf_line holds a real line
    logic  suppress;
    logic  repeat_line;

    // set until the first demand after reset or after a branch
    always_ff @(posedge clk) begin
        if (rst || branch_taken) begin
            suppress <= 1'b1;
        end else if (demand_start) begin
            suppress <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pf_valid <= 1'b0;
        end else if (prefetch_done) begin
            pf_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (demand_done) begin
            last_line <= {done_address[31:offset_bits], {offset_bits{1'b0}}};
        end else if (prefetch_done) begin
            last_line    <= prefetch_address;
            last_pf_line <= prefetch_address;
        end
    end

    // last use was the prefetched line itself, so no chained prefetch
    assign repeat_line = pf_valid && (last_line == last_pf_line);

    assign prefetch_address = last_line + addr_t'(line_bytes);
    assign prefetch_allowed = !suppress && !repeat_line;

endmodule

// ==== common/line_req_if.sv ====
`timescale 1ns/1ns

// one cache-line read between the prefetcher and the cache
interface line_req_if;
    import fetch_pkg::*;

    addr_t address;  // held stable while read is high
    logic  read;     // level, held until resp
    line_t rdata;    // valid only with resp
    logic  resp;     // single-cycle pulse

    // prefetcher side
    modport requester (
        output address,
        output read,
        input  rdata,
        input  resp
    );

    // cache side
    modport responder (
        input  address,
        input  read,
        output rdata,
        output resp
    );

endinterface

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

    // line and beat geometry
    localparam int unsigned line_bits      = 256;
    localparam int unsigned beat_bits      = 64;
    localparam int unsigned beats_per_line = line_bits / beat_bits;

    // address split
    localparam int unsigned offset_bits = 5;
    localparam int unsigned line_bytes  = 32;  // step to the next line
    localparam int unsigned index_bits  = 3;   // 8 lines
    localparam int unsigned tag_bits    = 32 - offset_bits - index_bits;

    typedef logic [31:0]          addr_t;
    typedef logic [line_bits-1:0] line_t;
    typedef logic [beat_bits-1:0] beat_t;

    // address helper types
    typedef logic [tag_bits-1:0]   tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [$clog2(beats_per_line)-1:0] beat_idx_t;

    // prefetcher control
    typedef enum logic [1:0] {
        idle,
        serve,     // cpu request owns the cache
        prefetch   // next-line fill, hidden from the cpu
    } pf_state_e;

endpackage
